// File: design/fetch_pkg.sv
package fetch_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths shared by the fetch front end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int ADDR_W      = 32;                    // byte address of a fetch or a bus read
    localparam int WORD_W      = 32;                    // one instruction is one bus word
    localparam int BLOCK_WORDS = 4;                     // words held in a single cache line
    localparam int BLOCK_W     = BLOCK_WORDS * WORD_W;  // a line is 16 bytes wide

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cache block seen as a whole line or as its words
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef union packed {
        logic [BLOCK_W-1:0]                  line;   // flat view used when the store is written
        logic [BLOCK_WORDS-1:0][WORD_W-1:0]  words;  // word 0 sits in the low 32 bits
    } icache_block_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        ST_LOOKUP   = 2'd0,  // compare the fetch address against the store
        ST_MEM_READ = 2'd1,  // waiting for the block reader to finish the line
        ST_FILL     = 2'd2   // line was written last edge and the word goes out now
    } ctrl_state_e;

endpackage

// File: design/icache_store.sv
`timescale 1ns/1ns

module icache_store #(
    parameter int INDEX_W = 4                                 // the store holds 2**INDEX_W lines
) (
    input  logic                             clk_i,
    input  logic                             rst_i,           // clears every valid bit

    input  logic [fetch_pkg::ADDR_W-1:0]     lookup_addr_i,   // current fetch address

    // fill from the controller at the same address
    input  logic                             fill_we_i,
    input  fetch_pkg::icache_block_u         fill_block_i,

    // combinational lookup result
    output logic                             hit_o,
    output fetch_pkg::icache_block_u         hit_block_o
);

    import fetch_pkg::*;

    localparam int LINES = 1 << INDEX_W;                      // direct mapped so one line per index
    localparam int TAG_W = ADDR_W - 4 - INDEX_W;

    logic [TAG_W-1:0]       tag_mem  [LINES];                 // tag kept for every line
    icache_block_u          data_mem [LINES];                 // 128 bit data of every line
    logic [LINES-1:0]       valid_r;                          // one bit per line

    logic [INDEX_W-1:0]     lookup_index;
    logic [TAG_W-1:0]       lookup_tag;

    assign lookup_index = lookup_addr_i[3+INDEX_W:4];
    assign lookup_tag   = lookup_addr_i[ADDR_W-1:4+INDEX_W];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the line is read whatever the tag says and only hit_o tells whether it is usable
    assign hit_o       = valid_r[lookup_index] && (tag_mem[lookup_index] == lookup_tag);
    assign hit_block_o = data_mem[lookup_index];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_r <= '0;                                    // every line starts out empty
        end else if (fill_we_i) begin
            valid_r[lookup_index] <= 1'b1;                    // the filled line becomes usable
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_we_i) begin
            tag_mem[lookup_index]  <= lookup_tag;             // a conflict simply overwrites the old tag
            data_mem[lookup_index] <= fill_block_i;
        end
    end

endmodule

// File: design/mem_block_reader.sv
`timescale 1ns/1ns

module mem_block_reader (
    input  logic                             clk_i,
    input  logic                             rst_i,           // synchronous and active low

    // controller side
    input  logic                             blk_req_i,       // one cycle pulse while idle
    input  logic [fetch_pkg::ADDR_W-1:0]     blk_addr_i,      // line base with low bits cleared
    input  logic                             blk_ack_i,       // controller has taken the block
    output logic                             mem_free_o,      // high while no block is in flight
    output logic                             blk_ready_o,     // held until blk_ack_i
    output fetch_pkg::icache_block_u         blk_data_o,      // assembled line

    // external word bus
    input  logic                             ext_rvalid_i,    // one cycle per returned word
    input  logic [fetch_pkg::WORD_W-1:0]     ext_rdata_i,
    output logic                             ext_req_o,       // one cycle pulse per word read
    output logic [fetch_pkg::ADDR_W-1:0]     ext_addr_o
);

    import fetch_pkg::*;

    localparam int CNT_W = $clog2(BLOCK_WORDS);
    localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(BLOCK_WORDS - 1);

    logic                   busy_r;                           // a block is being read or is waiting
    logic                   wait_r;                           // one word read is outstanding
    logic                   ready_r;                          // block done and not yet taken
    logic                   ext_req_r;                        // registered request pulse
    logic [CNT_W-1:0]       cnt_r;                            // word being read in this block
    logic [ADDR_W-1:4]      base_r;                           // line address of the block
    icache_block_u          block_r;                          // words collect here as they arrive

    // the counter forms the word address so each step moves four bytes
    assign ext_addr_o  = {base_r, cnt_r, 2'b00};
    assign ext_req_o   = ext_req_r;
    assign mem_free_o  = !busy_r;
    assign blk_ready_o = ready_r;
    assign blk_data_o  = block_r;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_r    <= 1'b0;                                // idle and free after reset
            wait_r    <= 1'b0;
            ready_r   <= 1'b0;
            ext_req_r <= 1'b0;
            cnt_r     <= '0;
        end else begin
            ext_req_r <= 1'b0;                                // request is only ever one cycle wide

            if (!busy_r && blk_req_i) begin
                busy_r    <= 1'b1;                            // first word goes out next cycle
                wait_r    <= 1'b1;
                ext_req_r <= 1'b1;
                cnt_r     <= '0;
            end else if (wait_r && ext_rvalid_i) begin
                if (cnt_r == LAST_WORD) begin
                    wait_r  <= 1'b0;                          // all words are in
                    ready_r <= 1'b1;                          // stays up through any stall
                end else begin
                    cnt_r     <= cnt_r + 1'b1;                // next word follows right away
                    ext_req_r <= 1'b1;
                end
            end else if (ready_r && blk_ack_i) begin
                ready_r <= 1'b0;                              // handed over so the reader is free
                busy_r  <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // block assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!busy_r && blk_req_i) begin
            base_r <= blk_addr_i[ADDR_W-1:4];                 // low four bits are always zero
        end
        if (wait_r && ext_rvalid_i) begin
            block_r.words[cnt_r] <= ext_rdata_i;              // word view puts it in its slot
        end
    end

endmodule

// File: design/icache_controller.sv
`timescale 1ns/1ns

module icache_controller #(
    parameter int INDEX_W = 4                                 // log2 of the number of cache lines
) (
    input  logic                             clk_i,
    input  logic                             rst_i,           // synchronous and active low
    input  logic                             stall_i,         // freezes the FSM and quiets outputs

    input  logic [fetch_pkg::ADDR_W-1:0]     fetch_addr_i,    // held stable until instr_valid_o

    // lookup result from the store
    input  logic                             hit_i,
    input  fetch_pkg::icache_block_u         hit_block_i,

    // block reader side
    input  logic                             mem_free_i,      // reader is idle and takes a request
    input  logic                             blk_ready_i,     // level held until blk_ack_o
    input  fetch_pkg::icache_block_u         blk_data_i,      // stays stable until the next request
    output logic                             blk_req_o,       // one cycle pulse per miss
    output logic [fetch_pkg::ADDR_W-1:0]     blk_addr_o,      // base of the missing line
    output logic                             blk_ack_o,       // takes the finished block

    // fill port of the store
    output logic                             fill_we_o,
    output fetch_pkg::icache_block_u         fill_block_o,

    // towards decode
    output logic [fetch_pkg::WORD_W-1:0]     instr_o,
    output logic                             instr_valid_o
);

    import fetch_pkg::*;

    localparam int TAG_W = ADDR_W - 4 - INDEX_W;              // whatever lies above the index field

    ctrl_state_e            state_r;                          // current FSM state
    ctrl_state_e            state_ns;                         // next FSM state
    logic [1:0]             offset_r;                         // word of the line that missed
    logic [1:0]             offset_ns;

    logic [TAG_W-1:0]       addr_tag;                         // tag field of the fetch address
    logic [INDEX_W-1:0]     addr_index;                       // line index of the fetch address
    logic [1:0]             addr_word;                        // word select inside the line

    assign addr_tag   = fetch_addr_i[ADDR_W-1:4+INDEX_W];
    assign addr_index = fetch_addr_i[3+INDEX_W:4];
    assign addr_word  = fetch_addr_i[3:2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state and output decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_ns      = state_r;                              // hold unless a branch below moves on
        offset_ns     = offset_r;
        instr_o       = '0;
        instr_valid_o = 1'b0;
        blk_req_o     = 1'b0;
        blk_addr_o    = '0;
        blk_ack_o     = 1'b0;
        fill_we_o     = 1'b0;
        fill_block_o  = '0;

        if (!stall_i) begin                                   // a stall leaves every output idle
            case (state_r)
                ST_LOOKUP: begin
                    if (hit_i) begin
                        instr_o       = hit_block_i.words[addr_word];  // hit goes out this cycle
                        instr_valid_o = 1'b1;
                    end else if (mem_free_i) begin
                        blk_req_o  = 1'b1;                    // ask for the whole line at once
                        blk_addr_o = {addr_tag, addr_index, 4'b0000};
                        offset_ns  = addr_word;               // keep the word that was asked for
                        state_ns   = ST_MEM_READ;
                    end
                end

                ST_MEM_READ: begin
                    if (blk_ready_i) begin
                        fill_we_o    = 1'b1;                  // line lands in the store this edge
                        fill_block_o = blk_data_i;
                        blk_ack_o    = 1'b1;                  // frees the reader for the next miss
                        state_ns     = ST_FILL;
                    end
                end

                ST_FILL: begin
                    // the reader still holds the block so the word is taken from there
                    instr_o       = blk_data_i.words[offset_r];
                    instr_valid_o = 1'b1;
                    state_ns      = ST_LOOKUP;
                end

                default: begin
                    state_ns = ST_LOOKUP;                     // unused encoding falls back to lookup
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_r <= ST_LOOKUP;                             // start out looking up addresses
        end else begin
            state_r <= state_ns;
        end
    end

    always_ff @(posedge clk_i) begin
        offset_r <= offset_ns;                                // the missing word waits here for the fill
    end

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit #(
    parameter int INDEX_W = 4                                 // 16 lines of 16 bytes each
) (
    input  logic                             clk_i,
    input  logic                             rst_i,           // synchronous and active low
    input  logic                             stall_i,
    input  logic [fetch_pkg::ADDR_W-1:0]     fetch_addr_i,

    output logic [fetch_pkg::WORD_W-1:0]     instr_o,
    output logic                             instr_valid_o,

    // external memory bus
    input  logic                             ext_rvalid_i,
    input  logic [fetch_pkg::WORD_W-1:0]     ext_rdata_i,
    output logic                             ext_req_o,
    output logic [fetch_pkg::ADDR_W-1:0]     ext_addr_o
);

    import fetch_pkg::*;

    logic                   hit;                              // store lookup result
    icache_block_u          hit_block;
    logic                   fill_we;                          // controller writes a line
    icache_block_u          fill_block;
    logic                   mem_free;                         // reader can take a request
    logic                   blk_req;
    logic [ADDR_W-1:0]      blk_addr;
    logic                   blk_ready;                        // held until acknowledged
    logic                   blk_ack;
    icache_block_u          blk_data;

    icache_controller #(
        .INDEX_W(INDEX_W)
    ) u_controller (
        .clk_i(clk_i),                .rst_i(rst_i),
        .stall_i(stall_i),            .fetch_addr_i(fetch_addr_i),
        .hit_i(hit),                  .hit_block_i(hit_block),
        .mem_free_i(mem_free),        .blk_ready_i(blk_ready),
        .blk_data_i(blk_data),        .blk_req_o(blk_req),
        .blk_addr_o(blk_addr),        .blk_ack_o(blk_ack),
        .fill_we_o(fill_we),          .fill_block_o(fill_block),
        .instr_o(instr_o),            .instr_valid_o(instr_valid_o)
    );

    icache_store #(
        .INDEX_W(INDEX_W)
    ) u_store (
        .clk_i(clk_i),                .rst_i(rst_i),
        .lookup_addr_i(fetch_addr_i), // fill reuses it since it is held during a miss
        .fill_we_i(fill_we),          .fill_block_i(fill_block),
        .hit_o(hit),                  .hit_block_o(hit_block)
    );

    mem_block_reader u_reader (
        .clk_i(clk_i),                .rst_i(rst_i),
        .blk_req_i(blk_req),          .blk_addr_i(blk_addr),
        .blk_ack_i(blk_ack),          .mem_free_o(mem_free),
        .blk_ready_o(blk_ready),      .blk_data_o(blk_data),
        .ext_rvalid_i(ext_rvalid_i),  .ext_rdata_i(ext_rdata_i),
        .ext_req_o(ext_req_o),        .ext_addr_o(ext_addr_o)
    );

endmodule

// File: testbench/fetch_unit_tb.sv
`timescale 1ns/1ns

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int    INDEX_W         = 4;                       // same line count as the top level
    localparam int    TAG_W           = ADDR_W - 4 - INDEX_W;
    localparam int    LINES           = 1 << INDEX_W;
    localparam int    CYCLES_PER_TEST = 60;                      // longest stalled miss fits well inside
    localparam string VECTOR_FILE     = "testbench/fetch_vectors.txt";

    logic                 clk_i = 1'b0;
    logic                 rst_i;
    logic                 stall_i;
    logic [ADDR_W-1:0]    fetch_addr_i;
    logic                 ext_rvalid_i;
    logic [WORD_W-1:0]    ext_rdata_i;
    logic [WORD_W-1:0]    instr_o;
    logic                 instr_valid_o;
    logic                 ext_req_o;
    logic [ADDR_W-1:0]    ext_addr_o;

    string                cmd_name  [$];                         // one entry per command line
    logic [ADDR_W-1:0]    cmd_addr  [$];
    int                   cmd_stall [$];
    logic [WORD_W-1:0]    mem_data  [logic [ADDR_W-3:0]];        // sparse memory keyed by word address
    logic [ADDR_W-1:0]    req_log   [$];                         // external reads seen in the current test
    logic [TAG_W-1:0]     ref_tag   [LINES];                     // reference copy of the cache tags
    bit   [LINES-1:0]     ref_valid;
    logic [31:0]          lfsr_state     = 32'ha2ea;
    bit                   vectors_loaded = 1'b0;
    int                   error_count    = 0;
    int                   tests_run      = 0;
    int                   tests_failed   = 0;

    fetch_unit #(
        .INDEX_W(INDEX_W)
    ) dut (
        .clk_i(clk_i),                .rst_i(rst_i),
        .stall_i(stall_i),            .fetch_addr_i(fetch_addr_i),
        .instr_o(instr_o),            .instr_valid_o(instr_valid_o),
        .ext_rvalid_i(ext_rvalid_i),  .ext_rdata_i(ext_rdata_i),
        .ext_req_o(ext_req_o),        .ext_addr_o(ext_addr_o)
    );

    always #5 clk_i = ~clk_i;                                    // 10 ns period

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};           // taps 32 22 2 1
    endfunction

    function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] byte_addr);
        if (mem_data.exists(byte_addr[ADDR_W-1:2])) begin
            return mem_data[byte_addr[ADDR_W-1:2]];
        end else begin
            return byte_addr ^ 32'h0bad_f00d;                    // words not in the file follow the address
        end
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic load_vectors(output bit ok);
        int                fd;
        int                n;
        int                ch;
        int                s;
        string             kind;
        string             name;
        logic [ADDR_W-1:0] a;
        logic [WORD_W-1:0] d;

        ok = 1'b0;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                ch = $fgetc(fd);                                 // drop the rest of a comment line
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (kind == "M") begin
                n = $fscanf(fd, "%h %h", a, d);
                if (n != 2) begin
                    $display("a memory line in the vector file is incomplete");
                    $fclose(fd);
                    return;
                end
                mem_data[a[ADDR_W-3:0]] = d;                     // the file gives word addresses
            end else if (kind == "C") begin
                n = $fscanf(fd, "%s %h %d", name, a, s);
                if (n != 3) begin
                    $display("a command line in the vector file is incomplete");
                    $fclose(fd);
                    return;
                end
                cmd_name.push_back(name);
                cmd_addr.push_back(a);
                cmd_stall.push_back(s);
            end else begin
                $display("the vector file holds a line of unknown kind %s", kind);
                $fclose(fd);
                return;
            end
        end
        $fclose(fd);
        ok = (cmd_name.size() > 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // external memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : memory_model
        logic [ADDR_W-1:0] req_addr;
        int                delay;

        ext_rvalid_i = 1'b0;
        ext_rdata_i  = '0;
        forever begin
            @(posedge clk_i);
            #2;                                                  // requests are looked at mid cycle
            while (ext_req_o === 1'b1) begin
                req_addr = ext_addr_o;
                req_log.push_back(req_addr);
                delay = 0;
                repeat (2) begin                                 // two bits give 0 to 3 idle cycles
                    lfsr_state = lfsr_step(lfsr_state);
                    delay      = (delay << 1) | int'(lfsr_state[0]);
                end
                repeat (delay + 1) @(posedge clk_i);
                #1;
                ext_rvalid_i = 1'b1;
                ext_rdata_i  = mem_word(req_addr);
                @(posedge clk_i);
                #1;
                ext_rvalid_i = 1'b0;                             // the next request may already be up
                ext_rdata_i  = '0;
                #1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_reset();
        int errors_before;

        errors_before = error_count;
        @(posedge clk_i);                                        // valid bits are cleared here
        #1;
        stall_i = 1'b0;                                          // address 0 meets an empty store
        #3;
        check_value("reset", "instr_valid_o", 32'd0, 32'(instr_valid_o));
        check_value("reset", "ext_req_o", 32'd0, 32'(ext_req_o));
        @(posedge clk_i);                                        // reset spans two rising edges
        #1;
        rst_i   = 1'b1;
        stall_i = 1'b1;                                          // keeps address 0 from missing
        #3;
        check_value("reset", "ext_req_o after release", 32'd0, 32'(ext_req_o));
        ref_valid = '0;                                          // every line starts out absent
        report_test("reset", errors_before);
    endtask

    task automatic run_fetch(input int i);
        string              name;
        logic [ADDR_W-1:0]  addr;
        logic [ADDR_W-1:0]  base;
        logic [WORD_W-1:0]  expected;
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        int                 stall_len;
        int                 errors_before;
        int                 cyc;
        int                 k;
        bit                 hit_pred;
        bit                 done;

        name          = cmd_name[i];
        addr          = cmd_addr[i];
        stall_len     = cmd_stall[i];
        base          = {addr[ADDR_W-1:4], 4'b0000};
        expected      = mem_word(addr);
        idx           = addr[3+INDEX_W:4];
        tag           = addr[ADDR_W-1:4+INDEX_W];
        hit_pred      = ref_valid[idx] && (ref_tag[idx] == tag);
        errors_before = error_count;
        req_log.delete();

        @(posedge clk_i);
        #1;
        fetch_addr_i = addr;
        stall_i      = 1'b0;                                     // the miss request goes out this cycle
        #3;
        if (hit_pred) begin
            check_value(name, "instr_valid_o on hit", 32'd1, 32'(instr_valid_o));
            check_value(name, "instr_o on hit", expected, instr_o);
        end else begin
            check_value(name, "instr_valid_o on miss", 32'd0, 32'(instr_valid_o));
            cyc  = 0;
            done = 1'b0;
            while (!done) begin
                @(posedge clk_i);
                #1;
                cyc++;
                stall_i = (cyc <= stall_len);                    // stall covers the cycles after the request
                #3;
                if (stall_i) begin
                    check_value(name, "instr_valid_o in stall", 32'd0, 32'(instr_valid_o));
                end else if (instr_valid_o) begin
                    check_value(name, "instr_o on miss", expected, instr_o);
                    done = 1'b1;
                end
            end
            ref_valid[idx] = 1'b1;                               // a conflict replaces the old tag
            ref_tag[idx]   = tag;
            for (k = 0; k < req_log.size() && k < BLOCK_WORDS; k++) begin
                check_value(name, "ext_addr_o", base + 32'(4 * k), req_log[k]);
            end
        end

        // the held address hits one cycle later and reads nothing more
        @(posedge clk_i);
        #4;
        check_value(name, "instr_valid_o next cycle", 32'd1, 32'(instr_valid_o));
        check_value(name, "instr_o next cycle", expected, instr_o);
        check_value(name, "ext_req_o count", hit_pred ? 32'd0 : 32'd4, 32'(req_log.size()));
        report_test(name, errors_before);
    endtask

    initial begin : main_sequence
        bit ok;
        int i;

        rst_i        = 1'b0;
        stall_i      = 1'b1;                                     // keeps address 0 from missing at start
        fetch_addr_i = '0;
        load_vectors(ok);
        if (!ok) begin
            $display("the vector file %s could not be read", VECTOR_FILE);
            $display("Errors found");
            $finish;
        end else begin
            vectors_loaded = 1'b1;
            check_reset();
            for (i = 0; i < cmd_name.size(); i++) begin
                run_fetch(i);
            end
            $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
            if (error_count == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (vectors_loaded);
        repeat (cmd_name.size() * CYCLES_PER_TEST) @(posedge clk_i);
        $display("Timeout: the fetch tests did not finish within %0d cycles",
                 cmd_name.size() * CYCLES_PER_TEST);
        $display("Errors found");
        $finish;
    end

endmodule

// File: testbench/fetch_vectors.txt
# M word_address data : a word of the external memory, word address is the byte address / 4
# C test_name byte_address stall_cycles : one fetch, stall_i held for that many cycles after the miss
M 00000400 00500093
M 00000401 00a00113
M 00000402 002081b3
M 00000403 40110233
M 00000800 fff00293
M 00000801 0052f333
M 00000802 0062e3b3
M 00000803 00734433
M 00000410 00000517
M 00000411 01050513
M 00000412 00052583
M 00000413 00b52223
M 00000c1c 0000006f
M 00000c1d 00100073
M 00000c1e 30200073
M 00000c1f 10500073
C miss_first      00001008 0
C hit_same        00001008 0
C hit_word0       00001000 0
C hit_word1       00001004 0
C hit_word3       0000100c 0
C miss_index4     00001044 0
C hit_index4      00001040 0
C evict_conflict  00002004 0
C hit_conflict    0000200c 0
C evict_back      00001000 0
C hit_back        00001008 0
C stall_long      00003078 24
C hit_after_stall 0000307c 0
C stall_short     0000a0f0 2
C hit_fill_word   0000a0f4 0
C hit_index4_w3   0000104c 0

// File: fetch_unit.f
design/fetch_pkg.sv
design/icache_store.sv
design/mem_block_reader.sv
design/icache_controller.sv
design/fetch_unit.sv
testbench/fetch_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_unit_tb
FILELIST  ?= fetch_unit.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
